// File: tb.f
fetch_pkg.sv
if_stage.sv
inst_sram.sv
fetch_top.sv
tb_clock.sv
tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb.sv
`timescale 1ns/1ps

module tb;
    import fetch_pkg::*;

    localparam int NUM_ROWS    = 11;
    localparam int WAIT_LIMIT  = 200;
    localparam int DRIVE_DELAY = 1;
    localparam int MEM_WORDS   = 2**IMEM_DEPTH_LOG2;

    logic                       hold_reset;
    logic                       clk;
    logic                       reset;
    logic                       sram_stall;
    logic                       load_en;
    logic [IMEM_DEPTH_LOG2-1:0] load_addr;
    logic [31:0]                load_data;
    logic                       br_taken;
    logic                       br_stall;
    logic [31:0]                br_target;
    logic                       ertn_valid;
    logic [31:0]                era_pc;
    logic                       ex_valid;
    logic [31:0]                ex_entry;
    logic                       ds_allow_in;
    logic                       fs_valid;
    logic [31:0]                fs_pc;
    logic [31:0]                fs_inst;
    logic [EBUS_WIDTH-1:0]      fs_ebus;

    // scenario table, probabilities in sixteenths
    redirect_kind_e             row_kind [NUM_ROWS];
    logic [31:0]                row_target [NUM_ROWS];
    logic [3:0]                 row_p_ds_low [NUM_ROWS];
    logic [3:0]                 row_p_stall [NUM_ROWS];
    int                         row_count [NUM_ROWS];

    logic [31:0]                mem_copy [MEM_WORDS];
    logic [31:0]                lfsr_q;
    logic [31:0]                exp_pc;
    logic [3:0]                 cur_p_ds_low;
    logic [3:0]                 cur_p_stall;
    // what decode refused last cycle
    logic                       held_q;
    logic [31:0]                held_pc;
    logic [31:0]                held_inst;
    logic [EBUS_WIDTH-1:0]      held_ebus;

    tb_clock #(.PERIOD_NS(20), .RESET_CYCLES(3)) i_tb_clock (
        .hold_reset (hold_reset),
        .clk        (clk),
        .reset      (reset)
    );

    fetch_top i_fetch_top (
        .clk         (clk),
        .reset       (reset),
        .sram_stall  (sram_stall),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .br_taken    (br_taken),
        .br_stall    (br_stall),
        .br_target   (br_target),
        .ertn_valid  (ertn_valid),
        .era_pc      (era_pc),
        .ex_valid    (ex_valid),
        .ex_entry    (ex_entry),
        .ds_allow_in (ds_allow_in),
        .fs_valid    (fs_valid),
        .fs_pc       (fs_pc),
        .fs_inst     (fs_inst),
        .fs_ebus     (fs_ebus)
    );

    // fibonacci lfsr x^32+x^22+x^2+x+1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            bits   = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // true with probability p16 out of 16
    function automatic logic chance(input logic [3:0] p16);
        return take_bits(4) < 32'(p16);
    endfunction

    task automatic stop_run();
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic set_row(input int idx, input redirect_kind_e kind, input logic [31:0] target,
                           input logic [3:0] p_ds_low, input logic [3:0] p_stall,
                           input int count);
        row_kind[idx]     = kind;
        row_target[idx]   = target;
        row_p_ds_low[idx] = p_ds_low;
        row_p_stall[idx]  = p_stall;
        row_count[idx]    = count;
    endtask

    task automatic build_table();
        // plain stream, then back-pressure and memory stalls
        set_row(0, REDIR_NONE, 32'h0, 4'd0, 4'd0, 12);
        set_row(1, REDIR_NONE, 32'h0, 4'd6, 4'd0, 20);
        set_row(2, REDIR_NONE, 32'h0, 4'd0, 4'd6, 20);
        set_row(3, REDIR_NONE, 32'h0, 4'd5, 4'd5, 20);
        // redirects, higher sources pulse together with lower ones
        set_row(4, REDIR_BRANCH, 32'h1c00_0200, 4'd4, 4'd4, 16);
        set_row(5, REDIR_EXCEPTION, 32'h1c00_1000, 4'd4, 4'd4, 12);
        set_row(6, REDIR_ERTN, 32'h1c00_03f0, 4'd4, 4'd4, 12);
        // misaligned targets give an ADEF stream
        set_row(7, REDIR_BRANCH, 32'h1c00_0102, 4'd4, 4'd0, 4);
        set_row(8, REDIR_BRANCH, 32'h1c00_0040, 4'd4, 4'd4, 12);
        set_row(9, REDIR_EXCEPTION, 32'h1c00_0ffe, 4'd3, 4'd3, 3);
        set_row(10, REDIR_ERTN, 32'h1c00_0080, 4'd5, 4'd5, 16);
    endtask

    // new inputs a little after the edge, pulses end here
    task automatic drive_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
        br_taken    = 1'b0;
        ertn_valid  = 1'b0;
        ex_valid    = 1'b0;
        ds_allow_in = ~chance(cur_p_ds_low);
        sram_stall  = chance(cur_p_stall);
        br_stall    = chance(cur_p_stall);
    endtask

    // outputs settled by the falling edge
    task automatic sample_cycle(output logic taken);
        logic [EBUS_WIDTH-1:0] exp_ebus;
        logic [31:0]           exp_inst;
        @(negedge clk);
        taken = fs_valid && ds_allow_in;
        if (held_q) begin
            assert (fs_valid) else begin
                $display("fs_valid dropped while decode was refusing the instruction");
                stop_run();
            end
            assert (fs_pc == held_pc) else begin
                $display("FAIL fs_pc held: got %h expected %h", fs_pc, held_pc);
                stop_run();
            end
            assert (fs_ebus == held_ebus) else begin
                $display("FAIL fs_ebus held: got %h expected %h", fs_ebus, held_ebus);
                stop_run();
            end
            if (held_ebus == '0) begin
                assert (fs_inst == held_inst) else begin
                    $display("FAIL fs_inst held: got %h expected %h", fs_inst, held_inst);
                    stop_run();
                end
            end
        end
        held_q    = fs_valid && !ds_allow_in;
        held_pc   = fs_pc;
        held_inst = fs_inst;
        held_ebus = fs_ebus;
        if (taken) begin
            exp_ebus            = '0;
            exp_ebus[EBUS_ADEF] = exp_pc[1:0] != 2'b00;
            exp_inst            = mem_copy[exp_pc[IMEM_DEPTH_LOG2+1:2]];
            assert (fs_pc == exp_pc) else begin
                $display("FAIL fs_pc: got %h expected %h", fs_pc, exp_pc);
                stop_run();
            end
            assert (fs_ebus == exp_ebus) else begin
                $display("FAIL fs_ebus: got %h expected %h", fs_ebus, exp_ebus);
                stop_run();
            end
            // ADEF word never came from memory
            if (exp_ebus == '0) begin
                assert (fs_inst == exp_inst) else begin
                    $display("FAIL fs_inst: got %h expected %h", fs_inst, exp_inst);
                    stop_run();
                end
            end
            exp_pc = exp_pc + 32'd4;
        end
    endtask

    task automatic observe(input int count);
        logic taken;
        int   waited;
        for (int n = 0; n < count; n++) begin
            waited = 0;
            taken  = 1'b0;
            while (!taken) begin
                assert (waited < WAIT_LIMIT) else begin
                    $display("fetch stalled, nothing reached decode in %0d cycles", WAIT_LIMIT);
                    stop_run();
                end
                drive_cycle();
                sample_cycle(taken);
                waited++;
            end
        end
    endtask

    // winner gets target, losing sources point elsewhere
    task automatic pulse_redirect(input redirect_kind_e kind, input logic [31:0] target);
        drive_cycle();
        ds_allow_in = 1'b1;
        ex_entry    = target;
        era_pc      = (kind == REDIR_ERTN) ? target : target + 32'h100;
        br_target   = (kind == REDIR_BRANCH) ? target : target + 32'h200;
        ex_valid    = kind == REDIR_EXCEPTION;
        ertn_valid  = kind != REDIR_BRANCH;
        br_taken    = 1'b1;
        @(negedge clk);
        assert (!fs_valid) else begin
            $display("fs_valid was high during a redirect pulse");
            stop_run();
        end
        held_q = 1'b0;
        exp_pc = target;
    endtask

    initial begin
        int waited;
        lfsr_q       = 32'hef34;
        hold_reset   = 1'b1;
        sram_stall   = 1'b0;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        br_taken     = 1'b0;
        br_stall     = 1'b0;
        br_target    = '0;
        ertn_valid   = 1'b0;
        era_pc       = '0;
        ex_valid     = 1'b0;
        ex_entry     = '0;
        ds_allow_in  = 1'b0;
        cur_p_ds_low = '0;
        cur_p_stall  = '0;
        held_q       = 1'b0;
        exp_pc       = FETCH_RESET_PC + 32'd4;
        build_table();
        // boot loader fills memory while fetch sits in reset
        for (int i = 0; i < MEM_WORDS; i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            load_en     = 1'b1;
            load_addr   = i[IMEM_DEPTH_LOG2-1:0];
            load_data   = take_bits(32);
            mem_copy[i] = load_data;
        end
        @(posedge clk);
        #DRIVE_DELAY;
        load_en    = 1'b0;
        hold_reset = 1'b0;
        waited     = 0;
        while (reset) begin
            assert (waited < WAIT_LIMIT) else begin
                $display("reset was never released");
                stop_run();
            end
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            cur_p_ds_low = row_p_ds_low[r];
            cur_p_stall  = row_p_stall[r];
            if (row_kind[r] != REDIR_NONE) begin
                pulse_redirect(row_kind[r], row_target[r]);
            end
            observe(row_count[r]);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 3
) (
    input  logic hold_reset,
    output logic clk,
    output logic reset
);

    // edges counted since hold_reset dropped
    int unsigned cnt;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial cnt = 0;

    always @(posedge clk) begin
        if (hold_reset) begin
            cnt <= 0;
        end else if (cnt < RESET_CYCLES) begin
            cnt <= cnt + 1;
        end
    end

    // boot loader may stretch reset, then three more edges
    assign reset = hold_reset || (cnt < RESET_CYCLES);

endmodule

// File: fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  sram_stall,
    // boot loader port
    input  logic                                  load_en,
    input  logic [fetch_pkg::IMEM_DEPTH_LOG2-1:0] load_addr,
    input  logic [31:0]                           load_data,
    // redirects
    input  logic                                  br_taken,
    input  logic                                  br_stall,
    input  logic [31:0]                           br_target,
    input  logic                                  ertn_valid,
    input  logic [31:0]                           era_pc,
    input  logic                                  ex_valid,
    input  logic [31:0]                           ex_entry,
    // decode side
    input  logic                                  ds_allow_in,
    output logic                                  fs_valid,
    output logic [31:0]                           fs_pc,
    output logic [31:0]                           fs_inst,
    output logic [fetch_pkg::EBUS_WIDTH-1:0]      fs_ebus
);

    // fetch stage to memory
    logic        inst_sram_req;
    logic [31:0] inst_sram_addr;
    logic        inst_sram_addr_ok;
    logic        inst_sram_data_ok;
    logic [31:0] inst_sram_rdata;

    if_stage i_if_stage (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata),
        .br_taken          (br_taken),
        .br_stall          (br_stall),
        .br_target         (br_target),
        .ertn_valid        (ertn_valid),
        .era_pc            (era_pc),
        .ex_valid          (ex_valid),
        .ex_entry          (ex_entry),
        .ds_allow_in       (ds_allow_in),
        .fs_valid          (fs_valid),
        .fs_pc             (fs_pc),
        .fs_inst           (fs_inst),
        .fs_ebus           (fs_ebus)
    );

    inst_sram i_inst_sram (
        .clk               (clk),
        .reset             (reset),
        .sram_stall        (sram_stall),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata),
        .load_en           (load_en),
        .load_addr         (load_addr),
        .load_data         (load_data)
    );

endmodule

// File: inst_sram.sv
`timescale 1ns/1ps

module inst_sram (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  sram_stall,
    // fetch side
    input  logic                                  inst_sram_req,
    input  logic [31:0]                           inst_sram_addr,
    output logic                                  inst_sram_addr_ok,
    output logic                                  inst_sram_data_ok,
    output logic [31:0]                           inst_sram_rdata,
    // boot loader, word indexed
    input  logic                                  load_en,
    input  logic [fetch_pkg::IMEM_DEPTH_LOG2-1:0] load_addr,
    input  logic [31:0]                           load_data
);
    import fetch_pkg::*;

    logic [31:0]                          mem [2**IMEM_DEPTH_LOG2];
    // in-order response queue
    logic [31:0]                          resp_data [SRAM_RESP_DEPTH];
    logic [$clog2(SRAM_RESP_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(SRAM_RESP_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(SRAM_RESP_DEPTH+1)-1:0] pend_cnt;
    logic                                 ready_q;
    logic                                 accept;
    logic [IMEM_DEPTH_LOG2-1:0]           rd_index;

    // byte address to word index, upper bits wrap
    assign rd_index = inst_sram_addr[IMEM_DEPTH_LOG2+1:2];

    // head of queue answers every cycle it is occupied
    assign inst_sram_data_ok = pend_cnt != '0;
    assign inst_sram_rdata   = resp_data[rd_ptr];

    // full queue still takes a new one if the head leaves now
    assign inst_sram_addr_ok = ready_q & ~sram_stall
                             & ((pend_cnt < SRAM_RESP_DEPTH) | inst_sram_data_ok);
    assign accept            = inst_sram_req & inst_sram_addr_ok;

    always_ff @(posedge clk) begin
        if (reset) begin
            ready_q  <= 1'b0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            pend_cnt <= '0;
        end else begin
            // up one cycle after reset
            ready_q <= 1'b1;
            if (accept) begin
                wr_ptr <= (wr_ptr == SRAM_RESP_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (inst_sram_data_ok) begin
                rd_ptr <= (rd_ptr == SRAM_RESP_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            if (accept & ~inst_sram_data_ok) begin
                pend_cnt <= pend_cnt + 1'b1;
            end else if (~accept & inst_sram_data_ok) begin
                pend_cnt <= pend_cnt - 1'b1;
            end
        end
    end

    // array read at acceptance, word parked until its data_ok
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
        if (accept) begin
            resp_data[wr_ptr] <= mem[rd_index];
        end
    end

    // every answer comes exactly one cycle after its acceptance
    a_data_ok_follows_accept: assert property (
        @(posedge clk) disable iff (reset)
        inst_sram_data_ok |-> $past(accept)
    );

endmodule

// File: if_stage.sv
`timescale 1ns/1ps

module if_stage (
    input  logic                             clk,
    input  logic                             reset,
    // instruction sram, split request and response
    output logic                             inst_sram_req,
    output logic [31:0]                      inst_sram_addr,
    input  logic                             inst_sram_addr_ok,
    input  logic                             inst_sram_data_ok,
    input  logic [31:0]                      inst_sram_rdata,
    // redirects, each a one-cycle pulse
    input  logic                             br_taken,
    input  logic                             br_stall,
    input  logic [31:0]                      br_target,
    input  logic                             ertn_valid,
    input  logic [31:0]                      era_pc,
    input  logic                             ex_valid,
    input  logic [31:0]                      ex_entry,
    // toward decode
    input  logic                             ds_allow_in,
    output logic                             fs_valid,
    output logic [31:0]                      fs_pc,
    output logic [31:0]                      fs_inst,
    output logic [fetch_pkg::EBUS_WIDTH-1:0] fs_ebus
);
    import fetch_pkg::*;

    // pre-IF side
    logic                                 run_q;
    redirect_kind_e                       live_kind;
    logic [31:0]                          live_target;
    logic                                 redirect_now;
    redirect_kind_e                       redir_kind_q;
    logic [31:0]                          redir_target_q;
    redirect_kind_e                       sel_kind;
    logic [31:0]                          sel_target;
    logic [31:0]                          pc_next;
    logic                                 preif_adef;
    logic                                 preif_go;
    logic                                 handoff;
    // IF side
    logic [31:0]                          pc_q;
    logic                                 if_valid_q;
    logic                                 if_adef_q;
    logic                                 cancel_q;
    logic                                 if_live;
    logic                                 if_ready_go;
    logic                                 if_allow_in;
    logic                                 accept;
    logic [$clog2(SRAM_RESP_DEPTH+1)-1:0] out_cnt;
    logic                                 recv_from_sram;
    logic                                 recv_from_buf;
    logic                                 buf_capture;
    logic                                 buf_valid_q;
    logic [31:0]                          buf_inst_q;
    logic                                 transfer;

    // stage comes up one cycle after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    // live pulses, highest priority first
    always_comb begin
        if (ex_valid) begin
            live_kind   = REDIR_EXCEPTION;
            live_target = ex_entry;
        end else if (ertn_valid) begin
            live_kind   = REDIR_ERTN;
            live_target = era_pc;
        end else if (br_taken) begin
            live_kind   = REDIR_BRANCH;
            live_target = br_target;
        end else begin
            live_kind   = REDIR_NONE;
            live_target = '0;
        end
    end

    assign redirect_now = live_kind != REDIR_NONE;

    // pulse lasts one cycle, so keep it until the target reaches IF
    // a fresh pulse supersedes whatever is retained
    always_ff @(posedge clk) begin
        if (reset) begin
            redir_kind_q <= REDIR_NONE;
        end else if (redirect_now) begin
            redir_kind_q <= live_kind;
        end else if (handoff) begin
            redir_kind_q <= REDIR_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (redirect_now) begin
            redir_target_q <= live_target;
        end
    end

    assign sel_kind   = redirect_now ? live_kind : redir_kind_q;
    assign sel_target = redirect_now ? live_target : redir_target_q;
    assign pc_next    = (sel_kind != REDIR_NONE) ? sel_target : pc_q + 32'd4;

    // misaligned pc skips memory, goes to IF tagged
    assign preif_adef = pc_next[1:0] != 2'b00;

    // br_stall means the target is not known yet
    assign preif_go = run_q & ~br_stall & (preif_adef | inst_sram_addr_ok);
    assign handoff  = preif_go & if_allow_in;

    // no request unless IF can take the pc
    assign inst_sram_req  = run_q & ~br_stall & if_allow_in & ~preif_adef;
    assign inst_sram_addr = pc_next;
    assign accept         = inst_sram_req & inst_sram_addr_ok;

    // IF pc, also the base for pc plus 4
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= FETCH_RESET_PC;
        end else if (handoff) begin
            pc_q <= pc_next;
        end
    end

    // pc handed over during a redirect pulse enters already dead
    always_ff @(posedge clk) begin
        if (reset) begin
            if_valid_q <= 1'b0;
            if_adef_q  <= 1'b0;
        end else if (handoff) begin
            if_valid_q <= ~redirect_now;
            if_adef_q  <= preif_adef;
        end else if (transfer) begin
            if_valid_q <= 1'b0;
        end
    end

    // kill flag for the IF content, cleared when a new pc enters
    always_ff @(posedge clk) begin
        if (reset) begin
            cancel_q <= 1'b0;
        end else if (handoff) begin
            cancel_q <= 1'b0;
        end else if (redirect_now) begin
            cancel_q <= 1'b1;
        end
    end

    assign if_live = if_valid_q & ~cancel_q & ~redirect_now;

    // accepted but not yet answered
    always_ff @(posedge clk) begin
        if (reset) begin
            out_cnt <= '0;
        end else if (accept & ~inst_sram_data_ok) begin
            out_cnt <= out_cnt + 1'b1;
        end else if (~accept & inst_sram_data_ok) begin
            out_cnt <= out_cnt - 1'b1;
        end
    end

    // only the newest response belongs to IF
    // older ones come from cancelled fetches and are dropped
    assign recv_from_sram = out_cnt == 1;
    // word already came back and sits in the buffer
    assign recv_from_buf  = out_cnt == 0;

    assign if_ready_go = if_adef_q
                       | (recv_from_sram & inst_sram_data_ok)
                       | (recv_from_buf & buf_valid_q);

    assign fs_valid    = if_live & if_ready_go;
    assign transfer    = fs_valid & ds_allow_in;
    assign if_allow_in = ~if_live | (ds_allow_in & if_ready_go);

    // decode refuses the word in its data_ok cycle
    assign buf_capture = if_live & ~if_adef_q & recv_from_sram & inst_sram_data_ok
                       & ~ds_allow_in;

    always_ff @(posedge clk) begin
        if (reset) begin
            buf_valid_q <= 1'b0;
        end else if (buf_capture) begin
            buf_valid_q <= 1'b1;
        end else if (handoff | transfer) begin
            buf_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (buf_capture) begin
            buf_inst_q <= inst_sram_rdata;
        end
    end

    assign fs_pc   = pc_q;
    assign fs_inst = buf_valid_q ? buf_inst_q : inst_sram_rdata;

    always_comb begin
        fs_ebus            = '0;
        fs_ebus[EBUS_ADEF] = if_adef_q;
    end

    a_out_cnt_bound: assert property (
        @(posedge clk) disable iff (reset)
        out_cnt <= SRAM_RESP_DEPTH
    );

    // aligned redirect targets and pc plus 4 keep delivered pcs aligned
    a_fs_pc_aligned: assert property (
        @(posedge clk) disable iff (reset)
        fs_valid && !fs_ebus[EBUS_ADEF] |-> fs_pc[1:0] == 2'b00
    );

    // sram answers only what it accepted from us
    a_no_orphan_data: assert property (
        @(posedge clk) disable iff (reset)
        inst_sram_data_ok |-> out_cnt != '0
    );

endmodule

// File: fetch_pkg.sv
package fetch_pkg;

    // pc held in reset, first fetch goes out at this value plus 4
    localparam logic [31:0] FETCH_RESET_PC = 32'h1bff_fffc;

    // instruction memory size, in words, as a power of two
    localparam int IMEM_DEPTH_LOG2 = 8;

    // one-hot exception bus carried along with each instruction
    localparam int EBUS_WIDTH = 16;

    // address error on fetch
    localparam int EBUS_ADEF = 0;

    // requests the sram may hold between acceptance and data_ok
    localparam int SRAM_RESP_DEPTH = 2;

    // redirect source picked by pre-IF
    // listed from lowest to highest priority
    typedef enum logic [1:0] {
        REDIR_NONE,
        REDIR_BRANCH,
        REDIR_ERTN,
        REDIR_EXCEPTION
    } redirect_kind_e;

endpackage
